//--- Makefile
SIM        ?= verilator
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_sim_top
RTL_TOP    ?= sim_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   := TESTS FAILED
PASS_MSG   := TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
src/isa_pkg.sv
src/core_pkg.sv
src/regfile.sv
src/if_stage.sv
src/id_stage.sv
src/ex_stage.sv
src/mem_wb_stage.sv
src/sim_top.sv
test/tb_sim_top.sv

//--- src/core_pkg.sv
/* core widths and pipeline records */
package core_pkg;

  localparam int xlen = 64;
  localparam int imem_words = 256;
  localparam int dmem_words = 256;
  localparam logic [xlen-1:0] reset_pc = '0;

  typedef struct packed {
    logic [xlen-1:0]   pc;
    logic [31:0]       inst;
    logic [xlen-1:0]   operand_a;
    logic [xlen-1:0]   operand_b;
    logic [xlen-1:0]   store_data;
    logic [xlen-1:0]   branch_offset;
    isa_pkg::alu_op_t  alu_op;
    logic              is_branch;
    logic              branch_ne;
    logic              mem_read;
    logic              mem_write;
    logic              rd_write;
    logic [4:0]        rd_addr;
    logic              is_trap;
  } id_ex_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] store_data;
    logic            mem_read;
    logic            mem_write;
    logic            rd_write;
    logic [4:0]      rd_addr;
    logic            is_trap;
  } ex_mem_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
    logic            rd_write;
    logic [4:0]      rd_addr;
    logic [xlen-1:0] rd_data;
  } commit_t;

  // destination of an in-flight instruction, for the decode interlock
  typedef struct packed {
    logic       busy;
    logic [4:0] rd_addr;
  } dest_busy_t;

endpackage

//--- src/ex_stage.sv
/* execute and branch resolve */
`timescale 1ns/1ns

module ex_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      id_ex_valid,
  input  core_pkg::id_ex_t          id_ex,
  input  logic                      mem_allowin,
  output logic                      ex_allowin,
  output logic                      ex_mem_valid,
  output core_pkg::ex_mem_t         ex_mem,
  output core_pkg::dest_busy_t      ex_busy,
  output logic                      redirect,
  output logic [core_pkg::xlen-1:0] redirect_pc
);

  localparam int xlen = core_pkg::xlen;

  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic [xlen-1:0] alu_result;
  logic            taken;

  assign a = id_ex.operand_a;
  assign b = id_ex.operand_b;

  // loads and stores use alu_add for the address
  always_comb begin
    case (id_ex.alu_op)
      isa_pkg::alu_add:    alu_result = a + b;
      isa_pkg::alu_sub:    alu_result = a - b;
      isa_pkg::alu_and:    alu_result = a & b;
      isa_pkg::alu_or:     alu_result = a | b;
      isa_pkg::alu_xor:    alu_result = a ^ b;
      isa_pkg::alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
      isa_pkg::alu_pass_b: alu_result = b;
      default:             alu_result = a + b;
    endcase
  end

  assign taken = id_ex.is_branch && (id_ex.branch_ne ? (a != b) : (a == b));

  assign ex_allowin = !ex_mem_valid || mem_allowin;
  // fires only in the cycle the branch moves on
  assign redirect = id_ex_valid && taken && ex_allowin;
  assign redirect_pc = id_ex.pc + id_ex.branch_offset;

  assign ex_busy = '{busy: id_ex_valid && id_ex.rd_write, rd_addr: id_ex.rd_addr};

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_mem_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_mem_valid <= id_ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (ex_allowin) begin
      ex_mem.pc <= id_ex.pc;
      ex_mem.inst <= id_ex.inst;
      ex_mem.alu_result <= alu_result;
      ex_mem.store_data <= id_ex.store_data;
      ex_mem.mem_read <= id_ex.mem_read;
      ex_mem.mem_write <= id_ex.mem_write;
      ex_mem.rd_write <= id_ex.rd_write;
      ex_mem.rd_addr <= id_ex.rd_addr;
      ex_mem.is_trap <= id_ex.is_trap;
    end
  end

endmodule

//--- src/id_stage.sv
/* decode and interlock */
`timescale 1ns/1ns

module id_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      if_id_valid,
  input  logic [core_pkg::xlen-1:0] if_pc,
  input  logic [31:0]               if_inst,
  input  logic                      ex_allowin,
  input  logic                      redirect,
  input  core_pkg::dest_busy_t      ex_busy,
  input  core_pkg::dest_busy_t      mem_busy,
  output logic [4:0]                rs1_addr,
  output logic [4:0]                rs2_addr,
  input  logic [core_pkg::xlen-1:0] rs1_data,
  input  logic [core_pkg::xlen-1:0] rs2_data,
  output logic                      id_allowin,
  output logic                      id_ex_valid,
  output core_pkg::id_ex_t          id_ex
);

  localparam int xlen = core_pkg::xlen;

  isa_pkg::opcode_t  opcode;
  logic [2:0]        funct3;
  logic [xlen-1:0]   imm_i;
  logic [xlen-1:0]   imm_s;
  logic [xlen-1:0]   imm_b;
  logic [xlen-1:0]   imm_u;
  logic              uses_rs1;
  logic              uses_rs2;
  logic              rs1_hazard;
  logic              rs2_hazard;
  logic              stall;
  logic              slot_free;
  core_pkg::id_ex_t  dec;

  function automatic isa_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic sub);
    isa_pkg::alu_op_t op;
    case (f3)
      isa_pkg::f3_add: op = sub ? isa_pkg::alu_sub : isa_pkg::alu_add;
      isa_pkg::f3_slt: op = isa_pkg::alu_slt;
      isa_pkg::f3_xor: op = isa_pkg::alu_xor;
      isa_pkg::f3_or:  op = isa_pkg::alu_or;
      isa_pkg::f3_and: op = isa_pkg::alu_and;
      default:         op = isa_pkg::alu_add;
    endcase
    return op;
  endfunction

  function automatic logic hits(input logic [4:0] rs, input core_pkg::dest_busy_t dest);
    return rs != 5'd0 && dest.busy && dest.rd_addr == rs;
  endfunction

  assign opcode = isa_pkg::opcode_t'(if_inst[6:0]);
  assign funct3 = if_inst[14:12];
  assign rs1_addr = if_inst[19:15];
  assign rs2_addr = if_inst[24:20];

  assign imm_i = {{(xlen-12){if_inst[31]}}, if_inst[31:20]};
  assign imm_s = {{(xlen-12){if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
  assign imm_b = {{(xlen-12){if_inst[31]}}, if_inst[7], if_inst[30:25], if_inst[11:8], 1'b0};
  assign imm_u = {{(xlen-32){if_inst[31]}}, if_inst[31:12], 12'b0};

  always_comb begin
    dec = '0;
    dec.pc = if_pc;
    dec.inst = if_inst;
    dec.operand_a = rs1_data;
    dec.operand_b = rs2_data;
    dec.store_data = rs2_data;
    dec.branch_offset = imm_b;
    dec.alu_op = isa_pkg::alu_add;
    dec.rd_addr = if_inst[11:7];
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      isa_pkg::op_lui: begin
        dec.operand_b = imm_u;
        dec.alu_op = isa_pkg::alu_pass_b;
        dec.rd_write = 1'b1;
      end
      isa_pkg::op_imm: begin
        // bit 30 belongs to the immediate here
        dec.operand_b = imm_i;
        dec.alu_op = alu_sel(funct3, 1'b0);
        dec.rd_write = 1'b1;
        uses_rs1 = 1'b1;
      end
      isa_pkg::op_reg: begin
        dec.alu_op = alu_sel(funct3, if_inst[30]);
        dec.rd_write = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      isa_pkg::op_load: begin
        if (funct3 == isa_pkg::f3_dword) begin
          dec.operand_b = imm_i;
          dec.mem_read = 1'b1;
          dec.rd_write = 1'b1;
          uses_rs1 = 1'b1;
        end
      end
      isa_pkg::op_store: begin
        if (funct3 == isa_pkg::f3_dword) begin
          dec.operand_b = imm_s;
          dec.mem_write = 1'b1;
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
        end
      end
      isa_pkg::op_branch: begin
        if (funct3 == isa_pkg::f3_beq || funct3 == isa_pkg::f3_bne) begin
          dec.is_branch = 1'b1;
          dec.branch_ne = funct3 == isa_pkg::f3_bne;
          uses_rs1 = 1'b1;
          uses_rs2 = 1'b1;
        end
      end
      isa_pkg::op_trap: dec.is_trap = 1'b1;
      default: ;
    endcase
  end

  // no forwarding, wait until the producer has written back
  assign rs1_hazard = uses_rs1 && (hits(rs1_addr, ex_busy) || hits(rs1_addr, mem_busy));
  assign rs2_hazard = uses_rs2 && (hits(rs2_addr, ex_busy) || hits(rs2_addr, mem_busy));
  assign stall = if_id_valid && (rs1_hazard || rs2_hazard);

  assign slot_free = !id_ex_valid || ex_allowin;
  assign id_allowin = !if_id_valid || (slot_free && !stall);

  always_ff @(posedge clock) begin
    if (reset || redirect) begin
      id_ex_valid <= 1'b0;
    end else if (slot_free) begin
      id_ex_valid <= if_id_valid && !stall;
    end
  end

  always_ff @(posedge clock) begin
    if (slot_free) begin
      id_ex <= dec;
    end
  end

endmodule

//--- src/if_stage.sv
/* instruction fetch */
`timescale 1ns/1ns

module if_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      prog_write,
  input  logic [7:0]                prog_addr,
  input  logic [31:0]               prog_data,
  input  logic                      id_allowin,
  input  logic                      redirect,
  input  logic [core_pkg::xlen-1:0] redirect_pc,
  input  logic                      halt,
  output logic                      if_id_valid,
  output logic [core_pkg::xlen-1:0] if_pc,
  output logic [31:0]               if_inst
);

  localparam int imem_aw = $clog2(core_pkg::imem_words);

  logic [31:0]               imem [core_pkg::imem_words];
  logic [core_pkg::xlen-1:0] pc;
  logic [31:0]               fetch_word;
  logic                      fetch;

  assign fetch_word = imem[pc[imem_aw+1:2]];
  assign fetch = id_allowin && !halt && !redirect;

  // program load while the core sits in reset
  always_ff @(posedge clock) begin
    if (reset && prog_write) begin
      imem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= core_pkg::reset_pc;
      if_id_valid <= 1'b0;
    end else if (redirect && !halt) begin
      // kill the word fetched down the wrong path
      pc <= redirect_pc;
      if_id_valid <= 1'b0;
    end else if (fetch) begin
      pc <= pc + core_pkg::xlen'(4);
      if_id_valid <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fetch) begin
      if_pc <= pc;
      if_inst <= fetch_word;
    end
  end

endmodule

//--- src/isa_pkg.sv
/* rv64 subset encodings */
package isa_pkg;

  localparam logic [6:0] trap_opcode = 7'h6b;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_trap   = trap_opcode
  } opcode_t;

  // funct3 fields
  localparam logic [2:0] f3_add   = 3'b000;
  localparam logic [2:0] f3_slt   = 3'b010;
  localparam logic [2:0] f3_xor   = 3'b100;
  localparam logic [2:0] f3_or    = 3'b110;
  localparam logic [2:0] f3_and   = 3'b111;
  localparam logic [2:0] f3_beq   = 3'b000;
  localparam logic [2:0] f3_bne   = 3'b001;
  localparam logic [2:0] f3_dword = 3'b011;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_t;

endpackage

//--- src/mem_wb_stage.sv
/* memory access and writeback */
`timescale 1ns/1ns

module mem_wb_stage (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      ex_mem_valid,
  input  core_pkg::ex_mem_t         ex_mem,
  output logic                      mem_allowin,
  output core_pkg::dest_busy_t      mem_busy,
  output logic                      wb_write,
  output logic [4:0]                wb_addr,
  output logic [core_pkg::xlen-1:0] wb_data,
  input  logic [core_pkg::xlen-1:0] exit_value,
  output logic                      commit_valid,
  output core_pkg::commit_t         commit,
  output logic                      halted,
  output logic [7:0]                exit_code
);

  localparam int dmem_aw = $clog2(core_pkg::dmem_words);

  logic [core_pkg::xlen-1:0] dmem [core_pkg::dmem_words];
  logic [dmem_aw-1:0]        dmem_idx;
  logic [core_pkg::xlen-1:0] load_data;
  logic                      live;

  // nothing retires once the trap has gone through
  assign live = ex_mem_valid && !halted;
  assign mem_allowin = !halted;

  // doubleword index
  assign dmem_idx = ex_mem.alu_result[dmem_aw+2:3];
  assign load_data = dmem[dmem_idx];

  assign wb_write = live && ex_mem.rd_write;
  assign wb_addr = ex_mem.rd_addr;
  assign wb_data = ex_mem.mem_read ? load_data : ex_mem.alu_result;

  assign mem_busy = '{busy: wb_write, rd_addr: ex_mem.rd_addr};

  always_ff @(posedge clock) begin
    if (live && ex_mem.mem_write) begin
      dmem[dmem_idx] <= ex_mem.store_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid <= 1'b0;
      halted <= 1'b0;
    end else begin
      commit_valid <= live;
      if (live && ex_mem.is_trap) begin
        halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (live) begin
      commit.pc <= ex_mem.pc;
      commit.inst <= ex_mem.inst;
      commit.rd_write <= wb_write;
      commit.rd_addr <= wb_addr;
      // x0 always reads back as zero
      commit.rd_data <= (wb_addr == 5'd0) ? '0 : wb_data;
    end
    if (live && ex_mem.is_trap) begin
      exit_code <= exit_value[7:0];
    end
  end

endmodule

//--- src/regfile.sv
/* integer register file */
`timescale 1ns/1ns

module regfile (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [4:0]                rs1_addr,
  input  logic [4:0]                rs2_addr,
  output logic [core_pkg::xlen-1:0] rs1_data,
  output logic [core_pkg::xlen-1:0] rs2_data,
  input  logic                      wb_write,
  input  logic [4:0]                wb_addr,
  input  logic [core_pkg::xlen-1:0] wb_data,
  output logic [core_pkg::xlen-1:0] exit_value
);

  logic [core_pkg::xlen-1:0] regs [32];

  // same-cycle write is visible to the reader
  function automatic logic [core_pkg::xlen-1:0] read_port(input logic [4:0] addr);
    logic [core_pkg::xlen-1:0] value;
    if (addr == 5'd0) begin
      value = '0;
    end else if (wb_write && wb_addr == addr) begin
      value = wb_data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write && wb_addr != 5'd0) begin
      regs[wb_addr] <= wb_data;
    end
  end

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // a0 carries the exit code
  assign exit_value = regs[10];

endmodule

//--- src/sim_top.sv
/* rv64 pipeline top */
`timescale 1ns/1ns

module sim_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              prog_write,
  input  logic [7:0]        prog_addr,
  input  logic [31:0]       prog_data,
  output logic              commit_valid,
  output core_pkg::commit_t commit,
  output logic              halted,
  output logic [7:0]        exit_code
);

  // fetch to decode
  logic                      if_id_valid;
  logic [core_pkg::xlen-1:0] if_pc;
  logic [31:0]               if_inst;
  logic                      id_allowin;

  // decode to execute
  logic                      id_ex_valid;
  core_pkg::id_ex_t          id_ex;
  logic                      ex_allowin;
  logic [4:0]                rs1_addr;
  logic [4:0]                rs2_addr;
  logic [core_pkg::xlen-1:0] rs1_data;
  logic [core_pkg::xlen-1:0] rs2_data;

  // execute to memory
  logic                      ex_mem_valid;
  core_pkg::ex_mem_t         ex_mem;
  logic                      mem_allowin;
  core_pkg::dest_busy_t      ex_busy;
  core_pkg::dest_busy_t      mem_busy;
  logic                      redirect;
  logic [core_pkg::xlen-1:0] redirect_pc;

  // writeback
  logic                      wb_write;
  logic [4:0]                wb_addr;
  logic [core_pkg::xlen-1:0] wb_data;
  logic [core_pkg::xlen-1:0] exit_value;

  if_stage u_if (
    .clock       (clock),
    .reset       (reset),
    .prog_write  (prog_write),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .id_allowin  (id_allowin),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .halt        (halted),
    .if_id_valid (if_id_valid),
    .if_pc       (if_pc),
    .if_inst     (if_inst)
  );

  id_stage u_id (
    .clock       (clock),
    .reset       (reset),
    .if_id_valid (if_id_valid),
    .if_pc       (if_pc),
    .if_inst     (if_inst),
    .ex_allowin  (ex_allowin),
    .redirect    (redirect),
    .ex_busy     (ex_busy),
    .mem_busy    (mem_busy),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .id_allowin  (id_allowin),
    .id_ex_valid (id_ex_valid),
    .id_ex       (id_ex)
  );

  ex_stage u_ex (
    .clock        (clock),
    .reset        (reset),
    .id_ex_valid  (id_ex_valid),
    .id_ex        (id_ex),
    .mem_allowin  (mem_allowin),
    .ex_allowin   (ex_allowin),
    .ex_mem_valid (ex_mem_valid),
    .ex_mem       (ex_mem),
    .ex_busy      (ex_busy),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc)
  );

  mem_wb_stage u_mem_wb (
    .clock        (clock),
    .reset        (reset),
    .ex_mem_valid (ex_mem_valid),
    .ex_mem       (ex_mem),
    .mem_allowin  (mem_allowin),
    .mem_busy     (mem_busy),
    .wb_write     (wb_write),
    .wb_addr      (wb_addr),
    .wb_data      (wb_data),
    .exit_value   (exit_value),
    .commit_valid (commit_valid),
    .commit       (commit),
    .halted       (halted),
    .exit_code    (exit_code)
  );

  regfile u_regfile (
    .clock      (clock),
    .reset      (reset),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .wb_write   (wb_write),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data),
    .exit_value (exit_value)
  );

endmodule

//--- test/program_patterns.hex
// program word count, program words, commit count, then one commit per line
// as pc rd_write rd_addr rd_data, and last the exit code, all in hex
1e
123450b7 06400113 ff900193 00310233 404102b3 0030f333 005263b3 0023c433
0021a4b3 fff12593 00f47613 07066693 fff6c713 00510013 002007b3 00113623
00c13803 00180663 00100893 00200913 00f11663 00300993 00099663 00400a13
00500a93 00298663 fc678513 0000006b 00600b13 00700b93
18
0 1 1 12345000
4 1 2 64
8 1 3 fffffffffffffff9
c 1 4 5d
10 1 5 7
14 1 6 12345000
18 1 7 5f
1c 1 8 3b
20 1 9 1
24 1 b 0
28 1 c b
2c 1 d 7b
30 1 e ffffffffffffff84
34 1 0 0
38 1 f 64
3c 0 0 0
40 1 10 12345000
44 0 0 0
50 0 0 0
54 1 13 3
58 0 0 0
64 0 0 0
68 1 a 2a
6c 0 0 0
2a

//--- test/tb_sim_top.sv
/* rv64 pipeline testbench */
`timescale 1ns/1ns

module tb_sim_top;

  localparam int pattern_depth = 256;
  localparam int record_words = 4;

  logic              clock;
  logic              reset;
  logic              prog_write;
  logic [7:0]        prog_addr;
  logic [31:0]       prog_data;
  logic              commit_valid;
  core_pkg::commit_t commit;
  logic              halted;
  logic [7:0]        exit_code;

  logic [63:0] patterns [pattern_depth];
  int          prog_words;
  int          expected_commits;
  int          commit_base;
  logic [7:0]  expected_exit;
  int          commit_count;
  int          cycle_count;
  int          cycle_limit;
  int          mismatches;
  int          failures;
  logic        halt_seen;
  logic        running;

  sim_top dut (
    .clock        (clock),
    .reset        (reset),
    .prog_write   (prog_write),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .commit_valid (commit_valid),
    .commit       (commit),
    .halted       (halted),
    .exit_code    (exit_code)
  );

  always #2 clock = ~clock;

  always @(posedge clock) begin
    if (running) begin
      cycle_count <= cycle_count + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    mismatches++;
    $display("mismatch %s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic count_failure(input string what);
    failures++;
    $display("%s", what);
  endtask

  // one record per retired instruction, in program order
  task automatic check_commit();
    int          base;
    logic [63:0] exp_pc;
    logic [31:0] exp_inst;
    logic        exp_write;
    if (halt_seen) begin
      count_failure($sformatf("commit at pc %h appeared after the core halted", commit.pc));
    end else if (commit_count >= expected_commits) begin
      count_failure($sformatf("unexpected extra commit at pc %h", commit.pc));
    end else begin
      base = commit_base + commit_count * record_words;
      exp_pc = patterns[base];
      exp_inst = patterns[int'(exp_pc[9:2]) + 1][31:0];
      exp_write = patterns[base + 1][0];
      if (commit.pc !== exp_pc) begin
        report_mismatch($sformatf("commit %0d pc", commit_count), exp_pc, commit.pc);
      end
      if (commit.inst !== exp_inst) begin
        report_mismatch($sformatf("commit %0d inst", commit_count),
                        64'(exp_inst), 64'(commit.inst));
      end
      if (commit.rd_write !== exp_write) begin
        report_mismatch($sformatf("commit %0d rd_write", commit_count),
                        64'(exp_write), 64'(commit.rd_write));
      end
      // rd fields only mean something for writing instructions
      if (exp_write && commit.rd_addr !== patterns[base + 2][4:0]) begin
        report_mismatch($sformatf("commit %0d rd_addr", commit_count),
                        64'(patterns[base + 2][4:0]), 64'(commit.rd_addr));
      end
      if (exp_write && commit.rd_data !== patterns[base + 3]) begin
        report_mismatch($sformatf("commit %0d rd_data", commit_count),
                        patterns[base + 3], commit.rd_data);
      end
    end
    commit_count++;
  endtask

  always @(negedge clock) begin
    if (!reset && commit_valid) begin
      check_commit();
    end
    if (!reset && halt_seen && !halted) begin
      count_failure("halted dropped after the trap");
    end
    if (!reset) begin
      halt_seen = halted;
    end
  end

  task automatic load_program();
    for (int i = 0; i < prog_words; i++) begin
      @(negedge clock);
      prog_write = 1'b1;
      prog_addr = 8'(i);
      prog_data = patterns[i + 1][31:0];
    end
    @(negedge clock);
    prog_write = 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    prog_write = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    commit_count = 0;
    cycle_count = 0;
    mismatches = 0;
    failures = 0;
    halt_seen = 1'b0;
    running = 1'b0;
    expected_commits = 0;
    $readmemh("test/program_patterns.hex", patterns);
    prog_words = int'(patterns[0]);
    if ($isunknown(patterns[0]) || prog_words < 1 || prog_words > core_pkg::imem_words) begin
      count_failure("pattern file is missing or has a bad program word count");
    end else begin
      expected_commits = int'(patterns[prog_words + 1]);
      commit_base = prog_words + 2;
      expected_exit = patterns[commit_base + expected_commits * record_words][7:0];
      cycle_limit = expected_commits * 8 + 50;
      repeat (5) @(negedge clock);
      // reset stays high until the whole program is in
      load_program();
      if (commit_valid !== 1'b0 || halted !== 1'b0) begin
        count_failure("commit_valid or halted not low after reset");
      end
      reset = 1'b0;
      running = 1'b1;
      while (halted !== 1'b1 && cycle_count < cycle_limit) begin
        @(negedge clock);
      end
      if (halted !== 1'b1) begin
        count_failure($sformatf("timeout, the core never halted within %0d cycles",
                                cycle_limit));
      end else begin
        // stray commits after the trap show up here
        repeat (10) @(negedge clock);
        if (exit_code !== expected_exit) begin
          report_mismatch("exit_code", 64'(expected_exit), 64'(exit_code));
        end
        if (commit_count != expected_commits) begin
          count_failure($sformatf("core retired %0d instructions, expected %0d",
                                  commit_count, expected_commits));
        end
      end
    end
    $display("checked %0d commits: %0d mismatches, %0d other errors",
             commit_count, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
